/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module vector_retire_tb -Mdir obj_dir
	./obj_dir/Vvector_retire_tb | tee sim.log
	@! grep -q "Errors found" sim.log
	@grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/vector_retire_chk.sv */
// retire stage handshake checks
// bound to the top level, covers XRF hold, VRF pulse and reset state

`timescale 1ns/100ps

module vector_retire_chk #(
  parameter int NUM_SLOTS = 4,
  parameter int XLEN      = 32
) (
  input logic                                         clk,
  input logic                                         rst,
  input logic [NUM_SLOTS-1:0]                         rob_valid,
  input logic                                         rob_ready,
  input logic [NUM_SLOTS-1:0]                         vrf_valid,
  input logic [NUM_SLOTS-1:0]                         xrf_valid,
  input logic [NUM_SLOTS-1:0]                         xrf_ready,
  input logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] xrf_index,
  input logic [NUM_SLOTS*XLEN-1:0]                    xrf_data,
  input logic                                         vcsr_valid
);

  import retire_pkg::*;

  logic accept;  // new group this edge
  assign accept = rob_ready & (|rob_valid);

  ////////////////////////////////////////////////////////////
  // XRF write stays put until its ready
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_xrf_hold
    xrf_hold: assert property (@(posedge clk) disable iff (rst)
      xrf_valid[s] && !xrf_ready[s] |=> xrf_valid[s]
        && $stable(xrf_data[s*XLEN +: XLEN])
        && $stable(xrf_index[s*REG_INDEX_W +: REG_INDEX_W]))
      else $error("xrf write of slot %0d dropped or changed before ready", s);
  end

  // only a fresh accept may keep vrf_valid up
  vrf_pulse: assert property (@(posedge clk) disable iff (rst)
    (vrf_valid != '0) && !accept |=> (vrf_valid == '0))
    else $error("vrf_valid stayed high without a new group");

  reset_quiet: assert property (@(posedge clk)
    rst |=> (vrf_valid == '0) && (xrf_valid == '0) && !vcsr_valid && rob_ready)
    else $error("outputs not idle after reset");

endmodule

bind vector_retire vector_retire_chk #(
  .NUM_SLOTS(NUM_SLOTS),
  .XLEN(XLEN)
) vector_retire_chk_i (
  .clk(clk), .rst(rst), .rob_valid(rob_valid), .rob_ready(rob_ready),
  .vrf_valid(vrf_valid), .xrf_valid(xrf_valid), .xrf_ready(xrf_ready),
  .xrf_index(xrf_index), .xrf_data(xrf_data), .vcsr_valid(vcsr_valid)
);

/* sim/vector_retire_tb.sv */
// vector retire stage testbench
// table of retire groups with expected writes, then random XRF back-pressure

`timescale 1ns/100ps

module vector_retire_tb;

  import retire_pkg::*;

  localparam int NS      = DEF_NUM_SLOTS;
  localparam int VL      = DEF_VLEN;
  localparam int XL      = DEF_XLEN;
  localparam int VB      = VL / 8;
  localparam int IW      = REG_INDEX_W;
  localparam int IDX_W   = NS * IW;
  localparam int TIMEOUT = 50;  // cycles per wait

  typedef struct {
    string            name;
    logic [NS-1:0]    valid;
    logic [NS-1:0]    w_type;
    logic [NS-1:0]    w_valid;
    logic [NS-1:0]    trap;
    logic [IDX_W-1:0] idx;
    logic [NS*VB-1:0] act;         // body active bytes with filler types elsewhere
    int               hold;        // cycles of xrf_ready low after the group
    logic [NS-1:0]    exp_vrf;
    logic [NS-1:0]    exp_xrf;
    logic [NS*VB-1:0] exp_strobe;  // only slots in exp_vrf are compared
    logic             exp_vcsr;
    int               vcsr_slot;
  } row_t;

  logic                   clk;
  logic                   rst;
  logic [NS-1:0]          rob_valid;
  logic [NS-1:0]          rob_w_type;
  logic [NS-1:0]          rob_w_valid;
  logic [IDX_W-1:0]       rob_index;
  logic [NS*VL-1:0]       rob_data;
  byte_type_t [NS*VB-1:0] rob_byte_type;
  logic [NS-1:0]          rob_trap;
  vcsr_t [NS-1:0]         rob_vcsr;
  logic                   rob_ready;
  logic [NS-1:0]          vrf_valid;
  logic [IDX_W-1:0]       vrf_index;
  logic [NS*VL-1:0]       vrf_data;
  logic [NS*VB-1:0]       vrf_strobe;
  logic [NS-1:0]          xrf_valid;
  logic [IDX_W-1:0]       xrf_index;
  logic [NS*XL-1:0]       xrf_data;
  logic [NS-1:0]          xrf_ready;
  logic                   vcsr_valid;
  vcsr_t                  vcsr_data;

  row_t   rows[$];
  integer seed = 32'ha753_01bd;
  int     row_err;
  int     errors;
  int     checks;
  int     tests;
  bit     timed_out;

  vector_retire vector_retire_i (
    .clk(clk), .rst(rst), .rob_valid(rob_valid), .rob_w_type(rob_w_type),
    .rob_w_valid(rob_w_valid), .rob_index(rob_index), .rob_data(rob_data),
    .rob_byte_type(rob_byte_type), .rob_trap(rob_trap), .rob_vcsr(rob_vcsr),
    .rob_ready(rob_ready), .vrf_valid(vrf_valid), .vrf_index(vrf_index),
    .vrf_data(vrf_data), .vrf_strobe(vrf_strobe), .xrf_valid(xrf_valid),
    .xrf_index(xrf_index), .xrf_data(xrf_data), .xrf_ready(xrf_ready),
    .vcsr_valid(vcsr_valid), .vcsr_data(vcsr_data)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      row_err++;
    end
  endtask

  task automatic report(string name);
    $display("%-18s %s", name, (row_err == 0) ? "ok" : "FAILED");
    errors += row_err;
    tests++;
    row_err = 0;
  endtask

  task automatic add_row(string name, logic [NS-1:0] valid, logic [NS-1:0] w_type,
                         logic [NS-1:0] w_valid, logic [NS-1:0] trap,
                         logic [IDX_W-1:0] idx, logic [NS*VB-1:0] act, int hold,
                         logic [NS-1:0] exp_vrf, logic [NS-1:0] exp_xrf,
                         logic [NS*VB-1:0] exp_strobe, logic exp_vcsr, int vcsr_slot);
    row_t r;
    r.name       = name;
    r.valid      = valid;
    r.w_type     = w_type;
    r.w_valid    = w_valid;
    r.trap       = trap;
    r.idx        = idx;
    r.act        = act;
    r.hold       = hold;
    r.exp_vrf    = exp_vrf;
    r.exp_xrf    = exp_xrf;
    r.exp_strobe = exp_strobe;
    r.exp_vcsr   = exp_vcsr;
    r.vcsr_slot  = vcsr_slot;
    rows.push_back(r);
  endtask

  // fresh random data and vcsr per group with byte types from the active mask
  task automatic drive_group(logic [NS-1:0] valid, logic [NS-1:0] w_type,
                             logic [NS-1:0] w_valid, logic [NS-1:0] trap,
                             logic [IDX_W-1:0] idx, logic [NS*VB-1:0] act);
    logic [63:0] v;
    rob_valid   = valid;
    rob_w_type  = w_type;
    rob_w_valid = w_valid;
    rob_trap    = trap;
    rob_index   = idx;
    for (int w = 0; w < NS * VL / 32; w++) begin
      rob_data[w*32 +: 32] = $random(seed);
    end
    for (int s = 0; s < NS; s++) begin
      v = {$random(seed), $random(seed)};
      rob_vcsr[s] = v[39:0];
      for (int b = 0; b < VB; b++) begin
        if (act[s*VB+b]) begin
          rob_byte_type[s*VB+b] = BODY_ACTIVE;
        end else begin
          rob_byte_type[s*VB+b] = byte_type_t'(2'((b + s) % 3));  // never body active
        end
      end
    end
  endtask

  task automatic wait_ready(string what);
    int n;
    n = 0;
    while (!rob_ready && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!rob_ready) begin
      $display("timeout: rob_ready stayed low before %s", what);
      row_err++;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_xrf_slot(int s);
    check_value($sformatf("xrf_index[%0d]", s), 128'(xrf_index[s*IW +: IW]),
                128'(rob_index[s*IW +: IW]));
    check_value($sformatf("xrf_data[%0d]", s), 128'(xrf_data[s*XL +: XL]),
                128'(rob_data[s*VL +: XL]));  // low XLEN bits only
  endtask

  task automatic check_slots(int n);
    for (int s = 0; s < NS; s++) begin
      if (rows[n].exp_vrf[s]) begin
        check_value($sformatf("vrf_index[%0d]", s), 128'(vrf_index[s*IW +: IW]),
                    128'(rows[n].idx[s*IW +: IW]));
        check_value($sformatf("vrf_data[%0d]", s), vrf_data[s*VL +: VL], rob_data[s*VL +: VL]);
        check_value($sformatf("vrf_strobe[%0d]", s), 128'(vrf_strobe[s*VB +: VB]),
                    128'(rows[n].exp_strobe[s*VB +: VB]));
      end
      if (rows[n].exp_xrf[s]) begin
        check_xrf_slot(s);
      end
    end
  endtask

  // hold xrf_ready low and then release slots one per cycle from the oldest
  task automatic hold_xrf(logic [NS-1:0] first, int cycles);
    logic [NS-1:0] pend;
    pend = first;
    for (int h = 0; h < cycles; h++) begin
      @(posedge clk);
      #1;
      check_value("rob_ready", 128'(rob_ready), 128'(pend == '0));
      check_value("xrf_valid", 128'(xrf_valid), 128'(pend));
      check_value("vrf_valid", 128'(vrf_valid), 128'(0));
      check_value("vcsr_valid", 128'(vcsr_valid), 128'(0));
      for (int s = 0; s < NS; s++) begin
        if (pend[s]) begin
          check_xrf_slot(s);
        end
      end
    end
    for (int s = 0; s < NS; s++) begin
      xrf_ready = NS'(1 << s);
      #1;
      check_value("rob_ready", 128'(rob_ready), 128'((pend & ~xrf_ready) == '0));
      @(posedge clk);
      #1;
      pend[s] = 1'b0;
      check_value("xrf_valid", 128'(xrf_valid), 128'(pend));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // table rows and random groups
  ////////////////////////////////////////////////////////////

  task automatic apply_row(int n);
    drive_group(rows[n].valid, rows[n].w_type, rows[n].w_valid, rows[n].trap,
                rows[n].idx, rows[n].act);
    wait_ready(rows[n].name);
    if (!timed_out) begin
      @(posedge clk);  // accepting edge
      #1;
      rob_valid = '0;
      xrf_ready = (rows[n].hold > 0) ? '0 : '1;
      check_value("vrf_valid", 128'(vrf_valid), 128'(rows[n].exp_vrf));
      check_value("xrf_valid", 128'(xrf_valid), 128'(rows[n].exp_xrf));
      check_value("vcsr_valid", 128'(vcsr_valid), 128'(rows[n].exp_vcsr));
      check_slots(n);
      if (rows[n].exp_vcsr) begin
        check_value("vcsr_data", 128'(vcsr_data), 128'(rob_vcsr[rows[n].vcsr_slot]));
      end
      if (rows[n].hold > 0) begin
        hold_xrf(rows[n].exp_xrf, rows[n].hold);
      end else begin
        @(posedge clk);
        #1;
        check_value("vrf_valid", 128'(vrf_valid), 128'(0));  // pulses are gone
        check_value("vcsr_valid", 128'(vcsr_valid), 128'(0));
        check_value("xrf_valid", 128'(xrf_valid), 128'(0));
      end
      xrf_ready = '1;
    end
    report($sformatf("row %0d %s", n, rows[n].name));
  endtask

  task automatic random_drain(int groups);
    logic [NS-1:0] valid;
    logic [NS-1:0] pend;
    int            n;
    for (int g = 0; g < groups && !timed_out; g++) begin
      valid    = NS'($random(seed));
      valid[0] = 1'b1;
      drive_group(valid, '1, '1, '0, IDX_W'($random(seed)), '1);
      wait_ready($sformatf("random group %0d", g));
      if (!timed_out) begin
        @(posedge clk);
        #1;
        rob_valid = '0;
        pend      = valid;
        check_value("xrf_valid", 128'(xrf_valid), 128'(pend));
        n = 0;
        while (pend != '0 && n < TIMEOUT) begin
          xrf_ready = NS'($random(seed));
          #1;
          check_value("rob_ready", 128'(rob_ready), 128'((pend & ~xrf_ready) == '0));
          @(posedge clk);
          #1;
          pend = pend & ~xrf_ready;
          check_value("xrf_valid", 128'(xrf_valid), 128'(pend));
          for (int s = 0; s < NS; s++) begin
            if (pend[s]) begin
              check_xrf_slot(s);
            end
          end
          n++;
        end
        if (pend != '0) begin
          $display("timeout: xrf writes of random group %0d never drained", g);
          row_err++;
          timed_out = 1'b1;
        end
        xrf_ready = '1;
      end
      report($sformatf("random %0d", g));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    rob_valid     = '0;
    rob_w_type    = '0;
    rob_w_valid   = '0;
    rob_index     = '0;
    rob_data      = '0;
    rob_byte_type = '0;
    rob_trap      = '0;
    rob_vcsr      = '0;
    xrf_ready     = '1;
    // name, valid, w_type, w_valid, trap, index, active, hold,
    // vrf, xrf, strobe, vcsr, vcsr slot (slot 0 rightmost)
    add_row("byte enables", 4'hf, 4'h0, 4'hf, 4'h0, {5'd4, 5'd3, 5'd2, 5'd1},
            64'h0001_ffff_a5a5_0ff0, 0, 4'hf, 4'h0, 64'h0001_ffff_a5a5_0ff0, 0, 0);
    add_row("waw pair", 4'hf, 4'h0, 4'hf, 4'h0, {5'd9, 5'd7, 5'd8, 5'd7},
            64'hf000_00ff_ffff_ffff, 0, 4'hf, 4'h0, 64'hf000_00ff_ffff_ff00, 0, 0);
    add_row("waw chain", 4'hf, 4'h0, 4'hf, 4'h0, {4{5'd5}},
            64'h0003_00ff_0ff0_ffff, 0, 4'hf, 4'h0, 64'h0003_00fc_0f00_f000, 0, 0);
    add_row("trap slot 1", 4'hf, 4'b0100, 4'hf, 4'b1010, {5'd4, 5'd3, 5'd2, 5'd1},
            '1, 0, 4'b0011, 4'h0, '1, 1, 1);
    add_row("trap kills waw", 4'hf, 4'h0, 4'hf, 4'b0001, {4{5'd6}},
            '1, 0, 4'b0001, 4'h0, '1, 1, 0);
    add_row("xrf hold", 4'hf, 4'b1011, 4'hf, 4'h0, {5'd13, 5'd12, 5'd11, 5'd10},
            '1, 3, 4'b0100, 4'b1011, '1, 0, 0);
    add_row("sparse", 4'b1010, 4'h0, 4'hf, 4'b0001, {5'd9, 5'd4, 5'd4, 5'd4},
            64'h00ff_ffff_0f0f_ffff, 0, 4'b1010, 4'h0, 64'h00ff_ffff_0f0f_ffff, 0, 0);
    add_row("no write trap", 4'hf, 4'h0, 4'b0101, 4'b0100, {4{5'd2}},
            64'hffff_0ff0_ffff_ffff, 0, 4'b0101, 4'h0, 64'hffff_0ff0_ffff_f00f, 1, 2);
    add_row("mixed files", 4'hf, 4'b0101, 4'hf, 4'h0, {4{5'd3}},
            64'hff0f_ffff_00ff_ffff, 0, 4'b1010, 4'b0101, 64'hff0f_ffff_00f0_ffff, 0, 0);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("vrf_valid", 128'(vrf_valid), 128'(0));
    check_value("xrf_valid", 128'(xrf_valid), 128'(0));
    check_value("vcsr_valid", 128'(vcsr_valid), 128'(0));
    check_value("rob_ready", 128'(rob_ready), 128'(1));
    report("reset");
    for (int n = 0; n < rows.size() && !timed_out; n++) begin
      apply_row(n);
    end
    random_drain(6);
    $display("%0d tests, %0d checks, %0d failed", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/retire_pkg.sv
verilog/retire_decode.sv
verilog/waw_strobe.sv
verilog/retire_result.sv
verilog/vector_retire.sv
sim/vector_retire_chk.sv
sim/vector_retire_tb.sv

/* verilog/retire_decode.sv */
// retire decode
// trap cancellation, VRF/XRF write split, byte enables and trap CSR pick

`timescale 1ns/100ps

module retire_decode #(
  parameter  int NUM_SLOTS = 4,
  parameter  int VLEN      = 128,
  localparam int VLENB     = VLEN / 8
) (
  input  logic [NUM_SLOTS-1:0]                         rob_valid,
  input  logic [NUM_SLOTS-1:0]                         rob_w_type,   // 1 for XRF
  input  logic [NUM_SLOTS-1:0]                         rob_w_valid,
  input  retire_pkg::byte_type_t [NUM_SLOTS*VLENB-1:0] rob_byte_type,
  input  logic [NUM_SLOTS-1:0]                         rob_trap,
  input  retire_pkg::vcsr_t [NUM_SLOTS-1:0]            rob_vcsr,
  output logic [NUM_SLOTS-1:0]                         vrf_live,
  output logic [NUM_SLOTS-1:0]                         xrf_live,
  output logic [NUM_SLOTS*VLENB-1:0]                   byte_en,
  output logic                                         trap_hit,
  output retire_pkg::vcsr_t                            trap_vcsr
);

  import retire_pkg::*;

  logic [NUM_SLOTS-1:0] write_ok;  // writes, not behind a trap

  ////////////////////////////////////////////////////////////
  // trap prefix, slot 0 is the oldest
  ////////////////////////////////////////////////////////////

  always_comb begin : trap_scan
    logic killed;
    killed = 1'b0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      write_ok[s] = rob_valid[s] & rob_w_valid[s] & ~killed;
      // trapping slot still writes, younger ones do not
      killed = killed | (rob_valid[s] & rob_trap[s]);
    end
  end

  assign vrf_live = write_ok & ~rob_w_type;
  assign xrf_live = write_ok & rob_w_type;

  // byte enables straight from the type codes
  always_comb begin
    for (int i = 0; i < NUM_SLOTS * VLENB; i++) begin
      byte_en[i] = (rob_byte_type[i] == BODY_ACTIVE);
    end
  end

  ////////////////////////////////////////////////////////////
  // oldest trapping slot wins
  ////////////////////////////////////////////////////////////

  always_comb begin
    trap_hit  = 1'b0;
    trap_vcsr = '0;
    // scan young to old so the oldest hit is the last one kept
    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
      if (rob_valid[s] && rob_w_valid[s] && rob_trap[s]) begin
        trap_hit  = 1'b1;
        trap_vcsr = rob_vcsr[s];
      end
    end
  end

endmodule

/* verilog/retire_pkg.sv */
// retire stage shared definitions
// widths, destination byte type codes and vector CSR state

package retire_pkg;

  ////////////////////////////////////////////////////////////
  // top level defaults
  ////////////////////////////////////////////////////////////

  localparam int DEF_NUM_SLOTS = 4;    // uops retired per group
  localparam int DEF_VLEN      = 128;  // vector register bits
  localparam int DEF_XLEN      = 32;   // scalar register bits

  // register file index, same for VRF and XRF
  localparam int REG_INDEX_W = 5;

  ////////////////////////////////////////////////////////////
  // destination byte type
  ////////////////////////////////////////////////////////////

  // every byte of vd is tagged by the execute units
  // only body active bytes are written back, the rest keep old value
  typedef enum logic [1:0] {
    PRESTART      = 2'b00,  // below vstart
    TAIL          = 2'b01,  // at or above vl
    BODY_INACTIVE = 2'b10,  // masked off by v0
    BODY_ACTIVE   = 2'b11
  } byte_type_t;

  ////////////////////////////////////////////////////////////
  // vector CSR state
  ////////////////////////////////////////////////////////////

  localparam int VSTART_W = 16;
  localparam int VL_W     = 16;
  localparam int VTYPE_W  = 8;   // vma, vta, vsew, vlmul

  // restored on a trap so the handler sees the faulting element
  typedef struct packed {
    logic [VSTART_W-1:0] vstart;
    logic [VL_W-1:0]     vl;
    logic [VTYPE_W-1:0]  vtype;
  } vcsr_t;  // 40 bits

endpackage

/* verilog/retire_result.sv */
// retire output stage
// registers VRF, XRF and VCSR writes; holds XRF writes until ready

`timescale 1ns/100ps

module retire_result #(
  parameter  int NUM_SLOTS = 4,
  parameter  int VLEN      = 128,
  parameter  int XLEN      = 32,
  localparam int VLENB     = VLEN / 8
) (
  input  logic                                         clk,
  input  logic                                         rst,
  // from decode and WAW
  input  logic [NUM_SLOTS-1:0]                         rob_valid,
  input  logic [NUM_SLOTS-1:0]                         vrf_live,
  input  logic [NUM_SLOTS-1:0]                         xrf_live,
  input  logic [NUM_SLOTS*VLENB-1:0]                   strobe,
  input  logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] rob_index,
  input  logic [NUM_SLOTS*VLEN-1:0]                    rob_data,
  input  logic                                         trap_hit,
  input  retire_pkg::vcsr_t                            trap_vcsr,
  input  logic [NUM_SLOTS-1:0]                         xrf_ready,
  output logic                                         rob_ready,
  // VRF write, one-cycle pulse per slot
  output logic [NUM_SLOTS-1:0]                         vrf_valid,
  output logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] vrf_index,
  output logic [NUM_SLOTS*VLEN-1:0]                    vrf_data,
  output logic [NUM_SLOTS*VLENB-1:0]                   vrf_strobe,
  // XRF write, valid/ready per slot
  output logic [NUM_SLOTS-1:0]                         xrf_valid,
  output logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] xrf_index,
  output logic [NUM_SLOTS*XLEN-1:0]                    xrf_data,
  // vector CSR restore on trap
  output logic                                         vcsr_valid,
  output retire_pkg::vcsr_t                            vcsr_data
);

  import retire_pkg::*;

  logic accept;  // group taken this edge

  ////////////////////////////////////////////////////////////
  // group handshake
  ////////////////////////////////////////////////////////////

  // ready once every pending XRF write drains, same cycle counts
  assign rob_ready = ~|(xrf_valid & ~xrf_ready);
  assign accept    = rob_ready & (|rob_valid);

  ////////////////////////////////////////////////////////////
  // valids
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      vrf_valid  <= '0;
      xrf_valid  <= '0;
      vcsr_valid <= 1'b0;
    end else begin
      // VRF and VCSR have no ready, one pulse per group
      vrf_valid  <= accept ? vrf_live : '0;
      vcsr_valid <= accept & trap_hit;
      if (accept) begin
        xrf_valid <= xrf_live;  // old pending bits all drain this edge
      end else begin
        xrf_valid <= xrf_valid & ~xrf_ready;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      vrf_index  <= rob_index;
      vrf_data   <= rob_data;
      vrf_strobe <= strobe;
      if (trap_hit) begin
        vcsr_data <= trap_vcsr;
      end
    end
  end

  // XRF payload loads only for live slots, stays put while pending
  always_ff @(posedge clk) begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (accept && xrf_live[s]) begin
        xrf_index[s*REG_INDEX_W +: REG_INDEX_W] <= rob_index[s*REG_INDEX_W +: REG_INDEX_W];
        xrf_data[s*XLEN +: XLEN]                <= rob_data[s*VLEN +: XLEN];  // low bits
      end
    end
  end

endmodule

/* verilog/vector_retire.sv */
// vector retire stage top
// decode, WAW strobe filter and registered write-back to VRF, XRF and VCSR

`timescale 1ns/100ps

module vector_retire #(
  parameter  int NUM_SLOTS = retire_pkg::DEF_NUM_SLOTS,
  parameter  int VLEN      = retire_pkg::DEF_VLEN,
  parameter  int XLEN      = retire_pkg::DEF_XLEN,
  localparam int VLENB     = VLEN / 8
) (
  input  logic                                         clk,
  input  logic                                         rst,
  // reorder buffer, slot 0 oldest
  input  logic [NUM_SLOTS-1:0]                         rob_valid,
  input  logic [NUM_SLOTS-1:0]                         rob_w_type,
  input  logic [NUM_SLOTS-1:0]                         rob_w_valid,
  input  logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] rob_index,
  input  logic [NUM_SLOTS*VLEN-1:0]                    rob_data,
  input  retire_pkg::byte_type_t [NUM_SLOTS*VLENB-1:0] rob_byte_type,
  input  logic [NUM_SLOTS-1:0]                         rob_trap,
  input  retire_pkg::vcsr_t [NUM_SLOTS-1:0]            rob_vcsr,
  output logic                                         rob_ready,
  // VRF
  output logic [NUM_SLOTS-1:0]                         vrf_valid,
  output logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] vrf_index,
  output logic [NUM_SLOTS*VLEN-1:0]                    vrf_data,
  output logic [NUM_SLOTS*VLENB-1:0]                   vrf_strobe,
  // XRF
  output logic [NUM_SLOTS-1:0]                         xrf_valid,
  output logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] xrf_index,
  output logic [NUM_SLOTS*XLEN-1:0]                    xrf_data,
  input  logic [NUM_SLOTS-1:0]                         xrf_ready,
  // VCSR
  output logic                                         vcsr_valid,
  output retire_pkg::vcsr_t                            vcsr_data
);

  import retire_pkg::*;

  logic [NUM_SLOTS-1:0]       vrf_live;
  logic [NUM_SLOTS-1:0]       xrf_live;
  logic [NUM_SLOTS*VLENB-1:0] byte_en;
  logic [NUM_SLOTS*VLENB-1:0] strobe;    // after WAW
  logic                       trap_hit;
  vcsr_t                      trap_vcsr;

  retire_decode #(.NUM_SLOTS(NUM_SLOTS), .VLEN(VLEN)) retire_decode_i (
    .rob_valid(rob_valid), .rob_w_type(rob_w_type), .rob_w_valid(rob_w_valid),
    .rob_byte_type(rob_byte_type), .rob_trap(rob_trap), .rob_vcsr(rob_vcsr),
    .vrf_live(vrf_live), .xrf_live(xrf_live), .byte_en(byte_en),
    .trap_hit(trap_hit), .trap_vcsr(trap_vcsr)
  );

  waw_strobe #(.NUM_SLOTS(NUM_SLOTS), .VLEN(VLEN)) waw_strobe_i (
    .byte_en(byte_en), .vrf_live(vrf_live), .rob_index(rob_index), .strobe(strobe)
  );

  retire_result #(.NUM_SLOTS(NUM_SLOTS), .VLEN(VLEN), .XLEN(XLEN)) retire_result_i (
    .clk(clk), .rst(rst), .rob_valid(rob_valid), .vrf_live(vrf_live),
    .xrf_live(xrf_live), .strobe(strobe), .rob_index(rob_index), .rob_data(rob_data),
    .trap_hit(trap_hit), .trap_vcsr(trap_vcsr), .xrf_ready(xrf_ready),
    .rob_ready(rob_ready), .vrf_valid(vrf_valid), .vrf_index(vrf_index),
    .vrf_data(vrf_data), .vrf_strobe(vrf_strobe), .xrf_valid(xrf_valid),
    .xrf_index(xrf_index), .xrf_data(xrf_data), .vcsr_valid(vcsr_valid),
    .vcsr_data(vcsr_data)
  );

endmodule

/* verilog/waw_strobe.sv */
// write-after-write strobe filter
// drops bytes that a younger VRF write to the same register covers

`timescale 1ns/100ps

module waw_strobe #(
  parameter  int NUM_SLOTS = 4,
  parameter  int VLEN      = 128,
  localparam int VLENB     = VLEN / 8
) (
  input  logic [NUM_SLOTS*VLENB-1:0]                  byte_en,
  input  logic [NUM_SLOTS-1:0]                        vrf_live,
  input  logic [NUM_SLOTS*retire_pkg::REG_INDEX_W-1:0] rob_index,
  output logic [NUM_SLOTS*VLENB-1:0]                  strobe
);

  localparam int IW = retire_pkg::REG_INDEX_W;

  // per slot, bytes that some younger same-register write also covers
  logic [NUM_SLOTS*VLENB-1:0] over_en;

  ////////////////////////////////////////////////////////////
  // younger writer scan
  ////////////////////////////////////////////////////////////

  // any slot count, replaces the fixed four-entry case tree
  always_comb begin
    over_en = '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      for (int y = s + 1; y < NUM_SLOTS; y++) begin
        // empty and XRF slots never shadow a VRF write
        if (vrf_live[y] && (rob_index[y*IW +: IW] == rob_index[s*IW +: IW])) begin
          over_en[s*VLENB +: VLENB] =
            over_en[s*VLENB +: VLENB] | byte_en[y*VLENB +: VLENB];
        end
      end
    end
  end

  // youngest slot keeps all its bytes since over_en stays zero there
  assign strobe = byte_en & ~over_en;

endmodule
